// File: verilog/gfx_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared sizes, opcodes and data types of the 2D raster engine
// imported by every RTL unit and by the bench that builds commands
//////////////////////////////////////////////////////////////////////

`default_nettype none

package gfx_pkg;

    // framebuffer geometry in pixels
    localparam int FB_WIDTH  = 128;
    localparam int FB_HEIGHT = 128;
    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;

    // signed integer coordinates, wide enough for off-screen endpoints
    localparam int COORD_W = 12;

    // opcode field of a command word
    localparam int OP_POS = 28;
    localparam int OP_W   = 4;

    typedef logic signed [COORD_W-1:0] coord_t;

    // RGB565 style pixel, the engine does not look inside it
    typedef logic [15:0] pixel_t;

    typedef logic [15:0] vram_addr_t;

    // opcode in [31:28], payload in [15:0]
    typedef logic [31:0] cmd_word_t;

    // codes 0 and 9..15 are free and ignored by the command unit
    typedef enum logic [OP_W-1:0] {
        OP_SET_X0    = 4'h1,
        OP_SET_Y0    = 4'h2,
        OP_SET_X1    = 4'h3,
        OP_SET_Y1    = 4'h4,
        OP_SET_COLOR = 4'h5,
        OP_CLEAR     = 4'h6,
        OP_DRAW_LINE = 4'h7,
        OP_SWAP      = 4'h8
    } opcode_t;

endpackage

`default_nettype wire

// File: verilog/line_stepper.sv
//////////////////////////////////////////////////////////////////////
// integer Bresenham walker, one pixel per cycle from endpoint 0 to
// endpoint 1 inclusive; no clipping here, pixels may lie off screen
//////////////////////////////////////////////////////////////////////

`default_nettype none

module line_stepper
    import gfx_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   reset_i,
    input  wire logic   start_i,
    input  wire coord_t x0_i,
    input  wire coord_t y0_i,
    input  wire coord_t x1_i,
    input  wire coord_t y1_i,
    output logic        pix_valid_o,
    output coord_t      pix_x_o,
    output coord_t      pix_y_o,
    output logic        done_o
);

    // deltas need one bit more than a coordinate, the doubled error
    // one more again, so everything runs three bits wider
    logic signed [COORD_W+2:0] dx_raw;
    logic signed [COORD_W+2:0] dy_raw;
    logic signed [COORD_W+2:0] dx;
    logic signed [COORD_W+2:0] dy;
    logic signed [COORD_W+2:0] err;
    logic signed [COORD_W+2:0] e2;
    logic signed [COORD_W+2:0] err_next;
    logic                      step_x;
    logic                      step_y;
    logic                      x_neg;
    logic                      y_neg;
    coord_t                    end_x;
    coord_t                    end_y;

    assign dx_raw = (COORD_W+3)'(x1_i) - (COORD_W+3)'(x0_i);
    assign dy_raw = (COORD_W+3)'(y1_i) - (COORD_W+3)'(y0_i);

    // dx holds |x1-x0|, dy holds -|y1-y0|
    assign e2     = err <<< 1;
    assign step_x = (e2 >= dy);
    assign step_y = (e2 <= dx);

    always_comb begin
        err_next = err;
        if (step_x) begin
            err_next = err_next + dy;
        end
        if (step_y) begin
            err_next = err_next + dx;
        end
    end

    assign done_o = pix_valid_o && (pix_x_o == end_x) && (pix_y_o == end_y);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pix_valid_o <= 1'b0;
        end else if (start_i) begin
            pix_valid_o <= 1'b1;
        end else if (done_o) begin
            pix_valid_o <= 1'b0;
        end
    end

    // walker state, meaningful only while pix_valid_o is high
    always_ff @(posedge clk) begin
        if (start_i) begin
            pix_x_o <= x0_i;
            pix_y_o <= y0_i;
            end_x   <= x1_i;
            end_y   <= y1_i;
            x_neg   <= dx_raw < 0;
            y_neg   <= dy_raw < 0;
            dx      <= (dx_raw < 0) ? -dx_raw : dx_raw;
            dy      <= (dy_raw < 0) ? dy_raw : -dy_raw;
            err     <= ((dx_raw < 0) ? -dx_raw : dx_raw) + ((dy_raw < 0) ? dy_raw : -dy_raw);
        end else if (pix_valid_o && !done_o) begin
            err <= err_next;
            if (step_x) begin
                pix_x_o <= x_neg ? pix_x_o - coord_t'(1) : pix_x_o + coord_t'(1);
            end
            if (step_y) begin
                pix_y_o <= y_neg ? pix_y_o - coord_t'(1) : pix_y_o + coord_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/vram_writer.sv
//////////////////////////////////////////////////////////////////////
// VRAM write side: clips line pixels to the framebuffer, turns them
// into linear addresses and runs the full-screen clear sweep
//////////////////////////////////////////////////////////////////////

`default_nettype none

module vram_writer
    import gfx_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   reset_i,

    // pixel stream from the line stepper
    input  wire logic   pix_valid_i,
    input  wire coord_t pix_x_i,
    input  wire coord_t pix_y_i,
    input  wire pixel_t color_i,

    input  wire logic   clear_start_i,
    output logic        clear_done_o,

    // VRAM port, one write per cycle with vram_we_o high
    output logic        vram_we_o,
    output vram_addr_t  vram_addr_o,
    output pixel_t      vram_data_o
);

    logic       clear_active;
    logic       pix_inside;
    vram_addr_t pix_addr;

    // clip test, coordinates are signed so negatives fall out here
    assign pix_inside = (pix_x_i >= 0) && (pix_x_i < FB_WIDTH) &&
                        (pix_y_i >= 0) && (pix_y_i < FB_HEIGHT);

    assign pix_addr = vram_addr_t'(pix_y_i) * vram_addr_t'(FB_WIDTH) + vram_addr_t'(pix_x_i);

    // high together with the write of the last framebuffer word
    assign clear_done_o = clear_active && (vram_addr_o == vram_addr_t'(FB_PIXELS - 1));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            clear_active <= 1'b0;
            vram_we_o    <= 1'b0;
        end else if (clear_start_i) begin
            clear_active <= 1'b1;
            vram_we_o    <= 1'b1;
        end else if (clear_active) begin
            if (clear_done_o) begin
                clear_active <= 1'b0;
                vram_we_o    <= 1'b0;
            end
        end else begin
            vram_we_o <= pix_valid_i && pix_inside;
        end
    end

    // address and data; during a clear the data register keeps the
    // colour latched at clear start for the whole sweep
    always_ff @(posedge clk) begin
        if (clear_start_i) begin
            vram_addr_o <= '0;
            vram_data_o <= color_i;
        end else if (clear_active) begin
            if (!clear_done_o) begin
                vram_addr_o <= vram_addr_o + vram_addr_t'(1);
            end
        end else if (pix_valid_i) begin
            vram_addr_o <= pix_addr;
            vram_data_o <= color_i;
        end
    end

endmodule

`default_nettype wire

// File: verilog/gfx_cmd_unit.sv
//////////////////////////////////////////////////////////////////////
// command front end: takes words from the valid/ready stream, keeps
// the vertex and colour registers and starts clear and line jobs,
// holding the stream off until the running job reports done
//////////////////////////////////////////////////////////////////////

`default_nettype none

module gfx_cmd_unit
    import gfx_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset_i,

    // command stream
    input  wire logic      cmd_tvalid_i,
    output logic           cmd_tready_o,
    input  wire cmd_word_t cmd_tdata_i,

    // line stepper control
    output logic           line_start_o,
    output coord_t         x0_o,
    output coord_t         y0_o,
    output coord_t         x1_o,
    output coord_t         y1_o,
    input  wire logic      line_done_i,

    // clear sweep control
    output logic           clear_start_o,
    output pixel_t         color_o,
    input  wire logic      clear_done_i,

    output logic           swap_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CLEARING,
        ST_DRAWING
    } state_t;

    state_t  state;
    opcode_t opcode;
    coord_t  coord_arg;
    logic    cmd_accept;

    assign opcode     = opcode_t'(cmd_tdata_i[OP_POS +: OP_W]);
    assign coord_arg  = $signed(cmd_tdata_i[COORD_W-1:0]);
    assign cmd_accept = cmd_tvalid_i && cmd_tready_o;

    // only an idle unit takes words
    assign cmd_tready_o = (state == ST_IDLE);

    // vertex and colour registers, written on the acceptance edge
    always_ff @(posedge clk) begin
        if (reset_i) begin
            x0_o    <= '0;
            y0_o    <= '0;
            x1_o    <= '0;
            y1_o    <= '0;
            color_o <= '0;
        end else if (cmd_accept) begin
            case (opcode)
                OP_SET_X0:    x0_o    <= coord_arg;
                OP_SET_Y0:    y0_o    <= coord_arg;
                OP_SET_X1:    x1_o    <= coord_arg;
                OP_SET_Y1:    y1_o    <= coord_arg;
                OP_SET_COLOR: color_o <= cmd_tdata_i[15:0];
                default:      ;
            endcase
        end
    end

    // job sequencing, start and swap strobes last one cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state         <= ST_IDLE;
            line_start_o  <= 1'b0;
            clear_start_o <= 1'b0;
            swap_o        <= 1'b0;
        end else begin
            line_start_o  <= 1'b0;
            clear_start_o <= 1'b0;
            swap_o        <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (cmd_accept) begin
                        case (opcode)
                            OP_CLEAR: begin
                                clear_start_o <= 1'b1;
                                state         <= ST_CLEARING;
                            end
                            OP_DRAW_LINE: begin
                                line_start_o <= 1'b1;
                                state        <= ST_DRAWING;
                            end
                            OP_SWAP: begin
                                swap_o <= 1'b1;
                            end
                            // set words and unknown codes need no job
                            default: ;
                        endcase
                    end
                end

                ST_CLEARING: begin
                    // done arrives with the last clear write
                    if (clear_done_i) begin
                        state <= ST_IDLE;
                    end
                end

                ST_DRAWING: begin
                    // done arrives with the pixel at endpoint 1
                    if (line_done_i) begin
                        state <= ST_IDLE;
                    end
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/gfx_core.sv
//////////////////////////////////////////////////////////////////////
// raster engine top: command stream in, 16-bit pixel writes out
//////////////////////////////////////////////////////////////////////

`default_nettype none

module gfx_core
    import gfx_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset_i,

    input  wire logic      cmd_tvalid_i,
    output logic           cmd_tready_o,
    input  wire cmd_word_t cmd_tdata_i,

    output logic           vram_we_o,
    output vram_addr_t     vram_addr_o,
    output pixel_t         vram_data_o,

    output logic           swap_o
);

    logic   line_start;
    logic   line_done;
    coord_t x0;
    coord_t y0;
    coord_t x1;
    coord_t y1;
    logic   clear_start;
    logic   clear_done;
    pixel_t color;

    // pixel stream between stepper and writer
    logic   pix_valid;
    coord_t pix_x;
    coord_t pix_y;

    gfx_cmd_unit cmd_unit (
        .clk           (clk),
        .reset_i       (reset_i),
        .cmd_tvalid_i  (cmd_tvalid_i),
        .cmd_tready_o  (cmd_tready_o),
        .cmd_tdata_i   (cmd_tdata_i),
        .line_start_o  (line_start),
        .x0_o          (x0),
        .y0_o          (y0),
        .x1_o          (x1),
        .y1_o          (y1),
        .line_done_i   (line_done),
        .clear_start_o (clear_start),
        .color_o       (color),
        .clear_done_i  (clear_done),
        .swap_o        (swap_o)
    );

    line_stepper stepper (
        .clk         (clk),
        .reset_i     (reset_i),
        .start_i     (line_start),
        .x0_i        (x0),
        .y0_i        (y0),
        .x1_i        (x1),
        .y1_i        (y1),
        .pix_valid_o (pix_valid),
        .pix_x_o     (pix_x),
        .pix_y_o     (pix_y),
        .done_o      (line_done)
    );

    vram_writer writer (
        .clk           (clk),
        .reset_i       (reset_i),
        .pix_valid_i   (pix_valid),
        .pix_x_i       (pix_x),
        .pix_y_i       (pix_y),
        .color_i       (color),
        .clear_start_i (clear_start),
        .clear_done_o  (clear_done),
        .vram_we_o     (vram_we_o),
        .vram_addr_o   (vram_addr_o),
        .vram_data_o   (vram_data_o)
    );

endmodule

`default_nettype wire

// File: bench/gfx_properties.sv
//////////////////////////////////////////////////////////////////////
// concurrent assertions on the raster engine top, bound to gfx_core
//////////////////////////////////////////////////////////////////////

`default_nettype none

module gfx_properties
    import gfx_pkg::*;
(
    input wire logic       clk,
    input wire logic       reset_i,
    input wire logic       cmd_tready_i,
    input wire logic       vram_we_i,
    input wire vram_addr_t vram_addr_i,
    input wire logic       swap_i,
    input wire logic       clear_start_i,
    input wire logic       clear_done_i
);

    logic clearing;
    int   assert_failures = 0;

    // high from the first clear write up to the one with clear_done
    always_ff @(posedge clk) begin
        if (reset_i) begin
            clearing <= 1'b0;
        end else if (clear_start_i) begin
            clearing <= 1'b1;
        end else if (clear_done_i) begin
            clearing <= 1'b0;
        end
    end

    addr_in_range: assert property (@(posedge clk) disable iff (reset_i)
        vram_we_i |-> (vram_addr_i < FB_PIXELS))
        else begin
            assert_failures++;
            $error("VRAM write address 0x%0h beyond the framebuffer", vram_addr_i);
        end

    swap_single: assert property (@(posedge clk) disable iff (reset_i)
        swap_i |=> !swap_i)
        else begin
            assert_failures++;
            $error("swap pulse longer than one cycle");
        end

    ready_low_in_clear: assert property (@(posedge clk) disable iff (reset_i)
        clearing |-> !cmd_tready_i)
        else begin
            assert_failures++;
            $error("command stream ready during a clear sweep");
        end

    // first cycle out of reset must not carry a write
    quiet_after_reset: assert property (@(posedge clk)
        $fell(reset_i) |=> !vram_we_i)
        else begin
            assert_failures++;
            $error("VRAM write right after reset");
        end

endmodule

bind gfx_core gfx_properties props (
    .clk           (clk),
    .reset_i       (reset_i),
    .cmd_tready_i  (cmd_tready_o),
    .vram_we_i     (vram_we_o),
    .vram_addr_i   (vram_addr_o),
    .swap_i        (swap_o),
    .clear_start_i (clear_start),
    .clear_done_i  (clear_done)
);

`default_nettype wire

// File: bench/gfx_checker.sv
//////////////////////////////////////////////////////////////////////
// bench checker: mirrors every VRAM write into a shadow framebuffer,
// counts writes and swap pulses, and offers check tasks to the bench
//////////////////////////////////////////////////////////////////////

`default_nettype none

module gfx_checker
    import gfx_pkg::*;
(
    input wire logic       clk,
    input wire logic       reset_i,
    input wire logic       vram_we_i,
    input wire vram_addr_t vram_addr_i,
    input wire pixel_t     vram_data_i,
    input wire logic       swap_i
);

    pixel_t     shadow [FB_PIXELS];
    int         write_count;
    int         swap_count;
    int         error_count;
    vram_addr_t prev_addr;
    int         order_breaks;

    task automatic report_mismatch(input string name, input int got, input int expected);
        $display("mismatch at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, expected);
        error_count++;
    endtask

    initial begin
        int a;
        // fill depends on the address so untouched words stand out
        for (a = 0; a < FB_PIXELS; a++) begin
            shadow[a] = pixel_t'(a) ^ 16'h5a5a;
        end
        write_count  = 0;
        swap_count   = 0;
        error_count  = 0;
        prev_addr    = '0;
        order_breaks = 0;
    end

    // DUT outputs are registered, so the values before the edge are sampled
    always @(posedge clk) begin
        if (!reset_i && vram_we_i) begin
            // a clear sweeps 0, 1, 2 ... so every other step counts
            if (write_count == 0 && vram_addr_i != '0) begin
                order_breaks++;
            end else if (write_count != 0 && vram_addr_i != prev_addr + vram_addr_t'(1)) begin
                order_breaks++;
            end
            prev_addr = vram_addr_i;
            write_count++;
            if (vram_addr_i >= FB_PIXELS) begin
                $display("%0t: write to address 0x%0h outside the framebuffer",
                         $time, vram_addr_i);
                error_count++;
            end else begin
                shadow[vram_addr_i] = vram_data_i;
            end
        end
        if (!reset_i && swap_i) begin
            swap_count++;
        end
    end

    task automatic start_test();
        write_count  = 0;
        swap_count   = 0;
        order_breaks = 0;
    endtask

    task automatic check_counts(input int exp_writes, input int exp_swaps);
        if (write_count != exp_writes) begin
            report_mismatch("write count", write_count, exp_writes);
        end
        if (swap_count != exp_swaps) begin
            report_mismatch("swap count", swap_count, exp_swaps);
        end
    endtask

    task automatic check_pixel(input vram_addr_t addr, input pixel_t colour);
        if (shadow[addr] !== colour) begin
            report_mismatch($sformatf("shadow[0x%0h]", addr), shadow[addr], colour);
        end
    endtask

    // whole framebuffer, only the first bad word gets its own line
    task automatic check_fill(input pixel_t colour);
        int a;
        int bad;
        bad = 0;
        for (a = 0; a < FB_PIXELS; a++) begin
            if (shadow[a] !== colour) begin
                if (bad == 0) begin
                    report_mismatch($sformatf("shadow[0x%0h]", a), shadow[a], colour);
                end
                bad++;
            end
        end
        if (bad > 1) begin
            $display("%0d more shadow words differ from the clear colour", bad - 1);
        end
        if (order_breaks != 0) begin
            $display("%0t: clear writes did not ascend from address 0 without gaps", $time);
            error_count++;
        end
    endtask

endmodule

`default_nettype wire

// File: bench/gfx_tb.sv
//////////////////////////////////////////////////////////////////////
// testbench for the raster engine: plays the command words of the
// stim file into gfx_core and has the checker compare each test
//////////////////////////////////////////////////////////////////////

`default_nettype none

module gfx_tb
    import gfx_pkg::*;
();

    localparam int STIM_DEPTH = 256;
    // a full clear needs a bit more than FB_PIXELS cycles
    localparam int WAIT_LIMIT = 20000;

    logic        clk;
    logic        reset;
    logic        cmd_tvalid;
    logic        cmd_tready;
    cmd_word_t   cmd_tdata;
    logic        vram_we;
    vram_addr_t  vram_addr;
    pixel_t      vram_data;
    logic        swap;
    logic [31:0] stim [0:STIM_DEPTH-1];
    logic        timed_out;
    int          pass_count;
    int          fail_count;

    gfx_core uut (
        .clk          (clk),
        .reset_i      (reset),
        .cmd_tvalid_i (cmd_tvalid),
        .cmd_tready_o (cmd_tready),
        .cmd_tdata_i  (cmd_tdata),
        .vram_we_o    (vram_we),
        .vram_addr_o  (vram_addr),
        .vram_data_o  (vram_data),
        .swap_o       (swap)
    );

    gfx_checker chk (
        .clk         (clk),
        .reset_i     (reset),
        .vram_we_i   (vram_we),
        .vram_addr_i (vram_addr),
        .vram_data_i (vram_data),
        .swap_i      (swap)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // called 2 after a rising edge, returns 2 after the accepting edge
    task automatic send_word(input cmd_word_t word);
        int   waited;
        logic taken;
        waited     = 0;
        taken      = 1'b0;
        cmd_tvalid = 1'b1;
        cmd_tdata  = word;
        while (!taken && waited < WAIT_LIMIT) begin
            @(negedge clk);
            taken = cmd_tready;
            @(posedge clk);
            #2;
            waited++;
        end
        cmd_tvalid = 1'b0;
        if (!taken) begin
            $display("timeout: command word 0x%h was never accepted", word);
            timed_out = 1'b1;
        end
    endtask

    // idle means ready, and no write or swap for four cycles
    task automatic wait_idle();
        int waited;
        int quiet;
        waited = 0;
        quiet  = 0;
        while (quiet < 4 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            if (cmd_tready && !vram_we && !swap) begin
                quiet++;
            end else begin
                quiet = 0;
            end
            waited++;
        end
        @(posedge clk);
        #2;
        if (quiet < 4) begin
            $display("timeout: the engine did not return to idle");
            timed_out = 1'b1;
        end
    endtask

    initial begin
        int          ptr;
        int          count;
        int          idx;
        int          test_num;
        int          errors_before;
        int          exp_writes;
        logic [31:0] fill;
        reset      = 1'b1;
        cmd_tvalid = 1'b0;
        cmd_tdata  = '0;
        timed_out  = 1'b0;
        pass_count = 0;
        fail_count = 0;
        $readmemh("bench/gfx_stim.txt", stim);

        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;

        ptr      = 0;
        test_num = 0;
        while (stim[ptr] != 32'h0 && !timed_out) begin
            test_num++;
            errors_before = chk.error_count;
            chk.start_test();
            count = int'(stim[ptr]);
            ptr++;
            for (idx = 0; idx < count && !timed_out; idx++) begin
                send_word(stim[ptr + idx]);
            end
            ptr += count;
            if (!timed_out) begin
                wait_idle();
            end
            if (!timed_out) begin
                exp_writes = int'(stim[ptr]);
                fill       = stim[ptr + 1];
                count      = int'(stim[ptr + 2]);
                ptr += 3;
                if (fill != 32'hffff_ffff) begin
                    chk.check_fill(pixel_t'(fill));
                end
                for (idx = 0; idx < count; idx++) begin
                    chk.check_pixel(vram_addr_t'(stim[ptr + idx] >> 16),
                                    pixel_t'(stim[ptr + idx]));
                end
                ptr += count;
                chk.check_counts(exp_writes, int'(stim[ptr]));
                ptr++;
                if (chk.error_count == errors_before) begin
                    pass_count++;
                    $display("test %0d passed", test_num);
                end else begin
                    fail_count++;
                    $display("test %0d failed", test_num);
                end
            end else begin
                fail_count++;
                $display("test %0d stopped by a timeout", test_num);
            end
        end

        $display("%0d tests passed, %0d failed, %0d check errors, %0d assertion failures",
                 pass_count, fail_count, chk.error_count, uut.props.assert_failures);
        if (timed_out || fail_count != 0 || chk.error_count != 0 ||
            uut.props.assert_failures != 0) begin
            $display("ERRORS FOUND");
        end else begin
            $display("NO ERRORS");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/gfx_stim.txt
// per test: word count, command words; then expected write count, clear colour
// (ffffffff for none), pair count, pairs of addr<<16|colour, swap count
// 1: clear after reset
00000002 50001234 60000000
00004000 00001234 00000000 00000000
// 2: horizontal line (10,20)-(15,20)
00000006 500000f0 1000000a 20000014 3000000f 40000014 70000000
00000006 ffffffff 00000005 0a0a00f0 0a0c00f0 0a0f00f0 0a091234 0a101234 00000000
// 3: vertical line (40,5)-(40,9)
00000006 50000f00 10000028 20000005 30000028 40000009 70000000
00000005 ffffffff 00000005 02a80f00 03a80f00 04a80f00 02281234 05281234 00000000
// 4: diagonal (2,3)-(9,6), x is the long axis
00000006 500007e0 10000002 20000003 30000009 40000006 70000000
00000008 ffffffff 00000007 018207e0 020407e0 020507e0 028707e0
030907e0 02031234 01841234 00000000
// 5: diagonal (-3,-3)-(130,130), clipped on both ends
00000006 5000f800 10000ffd 20000ffd 30000082 40000082 70000000
00000080 ffffffff 00000005 0000f800 2040f800 3ffff800 00011234 3ffe1234 00000000
// 6: horizontal (-3,10)-(130,10), x clipped with y inside
00000006 5000001f 10000ffd 2000000a 30000082 4000000a 70000000
00000080 ffffffff 00000004 0500001f 057f001f 04ff1234 05801234 00000000
// 7: two swaps between unknown opcodes
00000005 80000000 00000000 90001234 80000000 f000ffff
00000000 ffffffff 00000001 0000f800 00000002
// 8: colour change offered while a clear runs
00000004 50000abc 60000000 50000555 80000000
00004000 00000abc 00000000 00000001
// end of list
00000000

// File: verilog.f
verilog/gfx_pkg.sv
verilog/line_stepper.sv
verilog/vram_writer.sv
verilog/gfx_cmd_unit.sv
verilog/gfx_core.sv
bench/gfx_properties.sv
bench/gfx_checker.sv
bench/gfx_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= gfx_tb
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
FILELIST  ?= verilog.f

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "ERRORS FOUND" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
